/* ctrl_pkg.sv */
package ctrl_pkg;

	localparam int WORD_W = 32;
	localparam int REG_ADDR_W = 4;
	localparam int OP_W = 4;
	localparam int CCR_W = 3;
	localparam int BE_W = 4;
	localparam logic [BE_W-1:0] BE_FULL = 4'hf;

	// top nibble of the instruction word
	typedef enum logic [3:0] {
		T_INH = 4'h0,
		T_CMP = 4'h3,
		T_ALU = 4'h7,
		T_LDI = 4'h8,
		T_LOAD = 4'h9,
		T_STORE = 4'ha,
		T_BRANCH = 4'hb
	} insn_class_t;

	typedef enum logic [1:0] {
		SZ_WORD = 2'd0,
		SZ_HALF = 2'd1,
		SZ_BYTE = 2'd2
	} mem_size_t;

	typedef enum logic [4:0] {
		S_RESET,
		S_FETCH,
		S_FETCH2,
		S_EVAL,
		S_ALU,
		S_ALU2,
		S_CMP,
		S_CMP2,
		S_LDI,
		S_MEM_ADDR,
		S_MEM_ADDR2,
		S_LOAD,
		S_STORE_DATA,
		S_STORE,
		S_WB,
		S_BRANCH,
		S_HALT
	} state_t;

	typedef enum logic [2:0] {
		ALU_ADD = 3'd0,
		ALU_SUB = 3'd1,
		ALU_AND = 3'd2,
		ALU_OR = 3'd3,
		ALU_XOR = 3'd4,
		ALU_LSL = 3'd5,
		ALU_ASR = 3'd6,
		ALU_LSR = 3'd7
	} alu_func_t;

	typedef enum logic [1:0] {ALU_B, ALU_SVAL, ALU_4} alu_in_t;
	typedef enum logic [1:0] {REG_ALU, REG_MDR, REG_UVAL} reg_in_t;
	typedef enum logic [1:0] {MDR_MDR, MDR_ALU, MDR_DBUS, MDR_A} mdr_in_t;
	typedef enum logic {MAR_MAR, MAR_ALU} mar_t;
	typedef enum logic [1:0] {PC_PC, PC_NEXT, PC_REL} pc_t;
	typedef enum logic {CCR_CCR, CCR_ALU} ccr_t;

endpackage

/* decode_if.sv */
`timescale 1ns/1ps

interface decode_if
	import ctrl_pkg::*;
();
	insn_class_t iclass;
	logic illegal; // unknown class or size bit set
	logic [OP_W-1:0] op;
	logic [REG_ADDR_W-1:0] ra;
	logic [REG_ADDR_W-1:0] rb;
	logic [REG_ADDR_W-1:0] rc;
	mem_size_t mem_size;
	logic branch_taken; // only ever high for branch class

	modport src (
		output iclass,
		output illegal,
		output op,
		output ra,
		output rb,
		output rc,
		output mem_size,
		output branch_taken
	);

	modport dst (
		input iclass,
		input illegal,
		input op,
		input ra,
		input rb,
		input rc,
		input mem_size,
		input branch_taken
	);

endinterface

/* insn_decode.sv */
`timescale 1ns/1ps

module insn_decode
	import ctrl_pkg::*;
(
	input logic [WORD_W-1:0] ir,
	input logic [CCR_W-1:0] ccr,
	decode_if.src dec
);

	insn_class_t cls;
	logic kept;
	logic taken;
	logic ccr_ltu;
	logic ccr_lt;
	logic ccr_eq;

	assign cls = insn_class_t'(ir[31:28]);
	assign {ccr_ltu, ccr_lt, ccr_eq} = ccr;

	always_comb
	begin
		case (cls)
			T_INH, T_CMP, T_ALU, T_LDI, T_LOAD, T_STORE, T_BRANCH: kept = 1'b1;
			default: kept = 1'b0;
		endcase
	end

	always_comb
	begin
		case (ir[27:24])
			4'h0: taken = 1'b1; // bra
			4'h1: taken = ccr_eq; // beq
			4'h2: taken = ~ccr_eq; // bne
			4'h3: taken = ~(ccr_ltu | ccr_eq); // bgtu
			4'h4: taken = ~(ccr_lt | ccr_eq); // bgt
			4'h5: taken = ~ccr_lt; // bge
			4'h6: taken = ccr_lt | ccr_eq; // ble
			4'h7: taken = ccr_lt; // blt
			4'h8: taken = ~ccr_ltu; // bgeu
			4'h9: taken = ccr_ltu; // bltu
			4'ha: taken = ccr_ltu | ccr_eq; // bleu
			default: taken = 1'b0;
		endcase
	end

	assign dec.iclass = cls;
	assign dec.illegal = ~kept | ir[0];
	assign dec.op = ir[27:24];
	assign dec.ra = ir[23:20];
	assign dec.rb = ir[19:16];
	assign dec.rc = ir[15:12];
	assign dec.branch_taken = (cls == T_BRANCH) && taken;

	always_comb
	begin
		case (ir[25:24])
			2'd1: dec.mem_size = SZ_HALF;
			2'd2: dec.mem_size = SZ_BYTE;
			default: dec.mem_size = SZ_WORD; // 3 also maps here
		endcase
	end

endmodule

/* dbus_master.sv */
`timescale 1ns/1ps

module dbus_master
	import ctrl_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	decode_if.dst dec,
	input logic mem_req,
	input logic mem_write,
	output logic mem_done,
	input logic [1:0] datbus_align,
	input logic datbus_stall,
	input logic datbus_ack,
	output logic datbus_cyc,
	output logic datbus_stb,
	output logic datbus_write,
	output logic [BE_W-1:0] byteenable
);

	logic pending;
	logic pending_write;
	logic issue;

	function automatic logic [BE_W-1:0] lane_enable(mem_size_t size, logic [1:0] align);
		logic [BE_W-1:0] be;
		case (size)
			SZ_HALF: be = align[1] ? 4'b0011 : 4'b1100;
			SZ_BYTE: be = 4'b1000 >> align; // big endian lanes
			default: be = BE_FULL;
		endcase
		return be;
	endfunction

	assign issue = (mem_req | pending) & ~datbus_stall & ~datbus_cyc;
	assign mem_done = datbus_cyc & datbus_ack;

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			pending <= 1'b0;
			datbus_cyc <= 1'b0;
			datbus_stb <= 1'b0;
			datbus_write <= 1'b0;
			byteenable <= BE_FULL;
		end
		else
		begin
			datbus_stb <= issue; // single cycle strobe
			if (issue)
			begin
				pending <= 1'b0;
				datbus_cyc <= 1'b1;
				datbus_write <= mem_req ? mem_write : pending_write;
				byteenable <= lane_enable(dec.mem_size, datbus_align);
			end
			else if (mem_req)
				pending <= 1'b1; // held through stall
			if (mem_done)
			begin
				datbus_cyc <= 1'b0;
				datbus_write <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk_i)
	begin
		if (mem_req)
			pending_write <= mem_write;
	end

endmodule

/* step_sequencer.sv */
`timescale 1ns/1ps

module step_sequencer
	import ctrl_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	decode_if.dst dec,
	input logic insbus_ack,
	input logic insbus_stall,
	output logic insbus_cyc,
	output logic insbus_stb,
	output logic ir_write,
	output logic mem_req,
	output logic mem_write,
	input logic mem_done,
	output alu_func_t alu_func,
	output alu_in_t alu2sel,
	output ccr_t ccrsel,
	output reg_in_t regsel,
	output mdr_in_t mdrsel,
	output mar_t marsel,
	output pc_t pcsel,
	output logic [REG_ADDR_W-1:0] reg_read_addr1,
	output logic [REG_ADDR_W-1:0] reg_read_addr2,
	output logic [REG_ADDR_W-1:0] reg_write_addr,
	output logic reg_write,
	output logic a_write,
	output logic b_write,
	output logic halt
);

	state_t state;
	state_t state_next;
	logic insbus_cyc_next;
	logic insbus_stb_next;
	logic mem_issued; // data cycle already requested

	assign halt = (state == S_HALT);

	always_ff @(posedge clk_i or posedge rst_i)
	begin
		if (rst_i)
		begin
			state <= S_RESET;
			insbus_cyc <= 1'b0;
			insbus_stb <= 1'b0;
			mem_issued <= 1'b0;
		end
		else
		begin
			state <= state_next;
			insbus_cyc <= insbus_cyc_next;
			insbus_stb <= insbus_stb_next;
			if (mem_done)
				mem_issued <= 1'b0;
			else if (mem_req)
				mem_issued <= 1'b1;
		end
	end

	always_comb
	begin
		state_next = state;
		insbus_cyc_next = insbus_cyc;
		insbus_stb_next = insbus_stb;
		ir_write = 1'b0;
		mem_req = 1'b0;
		mem_write = 1'b0;
		alu_func = ALU_ADD;
		alu2sel = ALU_B;
		ccrsel = CCR_CCR;
		regsel = REG_ALU;
		mdrsel = MDR_MDR;
		marsel = MAR_MAR;
		pcsel = PC_PC;
		reg_read_addr1 = dec.ra;
		reg_read_addr2 = dec.rb;
		reg_write_addr = dec.ra;
		reg_write = 1'b0;
		a_write = 1'b0;
		b_write = 1'b0;

		case (state)
			S_RESET: state_next = S_FETCH;
			S_FETCH:
			begin
				ir_write = 1'b1;
				if (!insbus_stall)
				begin
					insbus_cyc_next = 1'b1;
					insbus_stb_next = 1'b1;
					state_next = S_FETCH2;
				end
			end
			S_FETCH2:
			begin
				ir_write = 1'b1;
				insbus_stb_next = 1'b0;
				if (insbus_ack)
				begin
					insbus_cyc_next = 1'b0;
					pcsel = PC_NEXT;
					state_next = S_EVAL;
				end
			end
			S_EVAL:
			begin
				a_write = 1'b1;
				b_write = 1'b1;
				if (dec.iclass == T_ALU)
				begin
					reg_read_addr1 = dec.rb; // A <= rB, B <= rC
					reg_read_addr2 = dec.rc;
				end
				else if (dec.iclass == T_LOAD || dec.iclass == T_STORE)
					reg_read_addr1 = dec.rb; // base address
				if (dec.illegal)
					state_next = S_HALT;
				else
					case (dec.iclass)
						T_INH: state_next = (dec.op == 4'h0) ? S_FETCH : S_HALT; // only nop runs on
						T_CMP: state_next = S_CMP;
						T_ALU: state_next = S_ALU;
						T_LDI: state_next = S_LDI;
						T_LOAD, T_STORE: state_next = S_MEM_ADDR;
						T_BRANCH: state_next = S_BRANCH;
						default: state_next = S_HALT;
					endcase
			end
			S_ALU, S_ALU2:
			begin
				alu_func = alu_func_t'(dec.op[2:0]);
				alu2sel = dec.op[3] ? ALU_SVAL : ALU_B;
				if (state == S_ALU2)
				begin
					mdrsel = MDR_ALU;
					state_next = S_WB;
				end
				else
					state_next = S_ALU2;
			end
			S_CMP:
			begin
				alu_func = ALU_SUB;
				state_next = S_CMP2;
			end
			S_CMP2:
			begin
				alu_func = ALU_SUB; // held while flags latch
				ccrsel = CCR_ALU;
				state_next = S_FETCH;
			end
			S_LDI:
			begin
				regsel = REG_UVAL;
				reg_write = 1'b1;
				state_next = S_FETCH;
			end
			S_MEM_ADDR:
			begin
				alu2sel = ALU_SVAL; // base plus offset
				a_write = 1'b1; // A <= rA for store data
				state_next = S_MEM_ADDR2;
			end
			S_MEM_ADDR2:
			begin
				marsel = MAR_ALU;
				state_next = (dec.iclass == T_STORE) ? S_STORE_DATA : S_LOAD;
			end
			S_STORE_DATA:
			begin
				mdrsel = MDR_A;
				state_next = S_STORE;
			end
			S_LOAD:
			begin
				mdrsel = MDR_DBUS;
				mem_req = ~mem_issued;
				if (mem_done)
					state_next = S_WB;
			end
			S_STORE:
			begin
				mem_req = ~mem_issued;
				mem_write = 1'b1;
				if (mem_done)
					state_next = S_FETCH;
			end
			S_WB:
			begin
				regsel = REG_MDR; // rA <= MDR
				reg_write = 1'b1;
				state_next = S_FETCH;
			end
			S_BRANCH:
			begin
				if (dec.branch_taken)
					pcsel = PC_REL;
				state_next = S_FETCH;
			end
			S_HALT: state_next = S_HALT;
			default: state_next = S_HALT;
		endcase
	end

endmodule

/* control_unit.sv */
`timescale 1ns/1ps

module control_unit
	import ctrl_pkg::*;
(
	input logic clk_i,
	input logic rst_i,
	input logic [WORD_W-1:0] ir,
	input logic [CCR_W-1:0] ccr,
	output logic ir_write,
	input logic insbus_ack,
	input logic insbus_stall,
	output logic insbus_cyc,
	output logic insbus_stb,
	input logic datbus_ack,
	input logic datbus_stall,
	input logic [1:0] datbus_align,
	output logic datbus_cyc,
	output logic datbus_stb,
	output logic datbus_write,
	output logic [BE_W-1:0] byteenable,
	output alu_func_t alu_func,
	output alu_in_t alu2sel,
	output ccr_t ccrsel,
	output reg_in_t regsel,
	output mdr_in_t mdrsel,
	output mar_t marsel,
	output pc_t pcsel,
	output logic [REG_ADDR_W-1:0] reg_read_addr1,
	output logic [REG_ADDR_W-1:0] reg_read_addr2,
	output logic [REG_ADDR_W-1:0] reg_write_addr,
	output logic reg_write,
	output logic a_write,
	output logic b_write,
	output logic halt
);

	logic mem_req;
	logic mem_write;
	logic mem_done;

	decode_if dec ();

	insn_decode u_decode (
		.ir(ir),
		.ccr(ccr),
		.dec(dec.src)
	);

	dbus_master u_dbus (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dec(dec.dst),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_done(mem_done),
		.datbus_align(datbus_align),
		.datbus_stall(datbus_stall),
		.datbus_ack(datbus_ack),
		.datbus_cyc(datbus_cyc),
		.datbus_stb(datbus_stb),
		.datbus_write(datbus_write),
		.byteenable(byteenable)
	);

	step_sequencer u_seq (
		.clk_i(clk_i),
		.rst_i(rst_i),
		.dec(dec.dst),
		.insbus_ack(insbus_ack),
		.insbus_stall(insbus_stall),
		.insbus_cyc(insbus_cyc),
		.insbus_stb(insbus_stb),
		.ir_write(ir_write),
		.mem_req(mem_req),
		.mem_write(mem_write),
		.mem_done(mem_done),
		.alu_func(alu_func),
		.alu2sel(alu2sel),
		.ccrsel(ccrsel),
		.regsel(regsel),
		.mdrsel(mdrsel),
		.marsel(marsel),
		.pcsel(pcsel),
		.reg_read_addr1(reg_read_addr1),
		.reg_read_addr2(reg_read_addr2),
		.reg_write_addr(reg_write_addr),
		.reg_write(reg_write),
		.a_write(a_write),
		.b_write(b_write),
		.halt(halt)
	);

endmodule

/* tb_control_unit.sv */
`timescale 1ns/1ps

module tb_control_unit
	import ctrl_pkg::*;
();

	logic clk_i;
	logic rst_i;
	logic [WORD_W-1:0] ir;
	logic [CCR_W-1:0] ccr;
	logic ir_write;
	logic insbus_ack;
	logic insbus_stall;
	logic insbus_cyc;
	logic insbus_stb;
	logic datbus_ack;
	logic datbus_stall;
	logic [1:0] datbus_align;
	logic datbus_cyc;
	logic datbus_stb;
	logic datbus_write;
	logic [BE_W-1:0] byteenable;
	alu_func_t alu_func;
	alu_in_t alu2sel;
	ccr_t ccrsel;
	reg_in_t regsel;
	mdr_in_t mdrsel;
	mar_t marsel;
	pc_t pcsel;
	logic [REG_ADDR_W-1:0] reg_read_addr1;
	logic [REG_ADDR_W-1:0] reg_read_addr2;
	logic [REG_ADDR_W-1:0] reg_write_addr;
	logic reg_write;
	logic a_write;
	logic b_write;
	logic halt;

	// one entry per line of the data file
	int t_kind[$];
	logic [WORD_W-1:0] t_word[$];
	logic [CCR_W-1:0] t_flags[$];
	logic [1:0] t_align[$];
	int t_stall[$];
	logic [WORD_W-1:0] t_exp[$];

	int err_count = 0;
	int test_fail = 0;
	int wd_limit = 0;

	control_unit DUT (.*);

	initial
	begin
		clk_i = 1'b0;
		forever #20 clk_i = ~clk_i;
	end

	initial
	begin
		wait (wd_limit != 0);
		repeat (wd_limit) @(posedge clk_i);
		$display("watchdog: run did not finish within %0d cycles", wd_limit);
		$display("Simulation failed");
		$finish;
	end

	function automatic string kind_name(input int kind);
		case (kind)
			0: return "nop";
			1: return "alu";
			2: return "cmp";
			3: return "branch";
			4: return "load";
			5: return "store";
			6: return "halt";
			default: return "unknown";
		endcase
	endfunction

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_be(input string name, input logic [BE_W-1:0] exp,
		input logic [BE_W-1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %b actual %b", name, exp, act);
			err_count++;
		end
	endtask

	task automatic check_alu(input string name, input alu_func_t exp, input alu_func_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
			err_count++;
		end
	endtask

	task automatic check_sel(input string name, input alu_in_t exp, input alu_in_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %s actual %s", name, exp.name(), act.name());
			err_count++;
		end
	endtask

	task automatic check_pc(input string name, input pc_t exp, input pc_t act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %s actual %0d", name, exp.name(), act);
			err_count++;
		end
	endtask

	task automatic check_reg(input string name, input logic [REG_ADDR_W-1:0] exp,
		input logic [REG_ADDR_W-1:0] act);
		if (act !== exp)
		begin
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			err_count++;
		end
	endtask

	task automatic read_tests();
		int fd;
		int n;
		int f_kind;
		int f_flags;
		int f_align;
		int f_stall;
		logic [WORD_W-1:0] f_word;
		logic [WORD_W-1:0] f_exp;
		string line;
		fd = $fopen("control_input.txt", "r");
		if (fd == 0)
		begin
			$display("could not open control_input.txt");
			err_count++;
		end
		else
		begin
			while (!$feof(fd))
			begin
				line = "";
				void'($fgets(line, fd));
				if (line.len() > 1 && line[0] != "#") // skip header and blank lines
				begin
					n = $sscanf(line, "%h %h %h %h %d %h", f_kind, f_word, f_flags, f_align,
						f_stall, f_exp);
					if (n == 6)
					begin
						t_kind.push_back(f_kind);
						t_word.push_back(f_word);
						t_flags.push_back(f_flags[CCR_W-1:0]);
						t_align.push_back(f_align[1:0]);
						t_stall.push_back(f_stall);
						t_exp.push_back(f_exp);
					end
					else
					begin
						$display("unreadable line in control_input.txt: %s", line);
						err_count++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic apply_reset();
		int errs_before;
		errs_before = err_count;
		@(posedge clk_i);
		rst_i <= 1'b1;
		repeat (3) @(posedge clk_i);
		@(negedge clk_i);
		check_bit("reset_insbus_cyc", 1'b0, insbus_cyc);
		check_bit("reset_insbus_stb", 1'b0, insbus_stb);
		check_bit("reset_datbus_cyc", 1'b0, datbus_cyc);
		check_bit("reset_datbus_stb", 1'b0, datbus_stb);
		check_bit("reset_datbus_write", 1'b0, datbus_write);
		check_be("reset_byteenable", BE_FULL, byteenable);
		check_bit("reset_halt", 1'b0, halt);
		check_bit("reset_reg_write", 1'b0, reg_write);
		check_bit("reset_a_write", 1'b0, a_write);
		check_bit("reset_b_write", 1'b0, b_write);
		check_bit("reset_ir_write", 1'b0, ir_write);
		@(posedge clk_i);
		rst_i <= 1'b0;
		$display("%-14s %s", "reset", (err_count == errs_before) ? "ok" : "FAILED");
	endtask

	task automatic run_test(input int idx);
		string name;
		int kind;
		int cycles;
		int stray;
		int dstb_count;
		int dstb_exp;
		int errs_before;
		logic [WORD_W-1:0] exp;
		logic done;
		logic ack_due;
		logic prev_dstall;
		logic rel_seen;
		logic wb_seen;
		logic alu_seen;
		logic halt_got;
		alu_func_t alu_got;
		alu_in_t sel_got;
		logic [BE_W-1:0] be_got;
		logic wr_got;
		logic mar_seen;
		logic opr_seen;
		logic [REG_ADDR_W-1:0] rd1_got;
		logic [REG_ADDR_W-1:0] rd2_got;
		kind = t_kind[idx];
		exp = t_exp[idx];
		name = $sformatf("t%0d_%s", idx, kind_name(kind));
		errs_before = err_count;
		stray = 0;
		dstb_count = 0;
		rel_seen = 1'b0;
		wb_seen = 1'b0;
		alu_seen = 1'b0;
		alu_got = ALU_ADD;
		sel_got = ALU_B;
		be_got = '0;
		wr_got = 1'b0;
		mar_seen = 1'b0;
		opr_seen = 1'b0;
		rd1_got = '0;
		rd2_got = '0;

		ccr <= t_flags[idx];
		datbus_align <= t_align[idx];
		datbus_stall <= 1'b1;
		for (cycles = 0; cycles < t_stall[idx]; cycles++)
		begin
			@(negedge clk_i);
			if (insbus_stb || insbus_cyc)
				stray++; // fetch must wait out the stall
			@(posedge clk_i);
		end
		insbus_stall <= 1'b0;
		do
			@(negedge clk_i);
		while (!insbus_stb);
		@(posedge clk_i);
		ir <= t_word[idx];
		insbus_ack <= 1'b1;
		insbus_stall <= 1'b1; // hold off the next fetch
		@(negedge clk_i);
		check_bit({name, "_fetch_cyc"}, 1'b1, insbus_cyc);
		check_bit({name, "_fetch_stb"}, 1'b0, insbus_stb);
		check_pc({name, "_fetch_pc"}, PC_NEXT, pcsel);
		@(posedge clk_i);
		insbus_ack <= 1'b0;

		done = 1'b0;
		ack_due = 1'b0;
		prev_dstall = 1'b1;
		halt_got = 1'b0;
		cycles = 0;
		while (!done)
		begin
			datbus_stall <= (cycles < t_stall[idx]);
			datbus_ack <= ack_due;
			@(negedge clk_i);
			ack_due = 1'b0;
			if (insbus_stb || insbus_cyc)
				stray++;
			if (datbus_stb)
			begin
				dstb_count++;
				if (prev_dstall)
				begin
					$display("%s: data strobe raised after a stalled cycle", name);
					err_count++;
				end
				be_got = byteenable;
				wr_got = datbus_write;
				ack_due = 1'b1; // ack in the next cycle
			end
			if (datbus_ack && !datbus_cyc)
			begin
				$display("%s: data cycle dropped before its ack", name);
				err_count++;
			end
			if (mdrsel == MDR_ALU)
			begin
				alu_seen = 1'b1;
				alu_got = alu_func;
				sel_got = alu2sel;
			end
			if (ccrsel == CCR_ALU)
			begin
				alu_seen = 1'b1;
				alu_got = alu_func;
			end
			if (pcsel == PC_REL)
				rel_seen = 1'b1;
			if (reg_write && regsel == REG_MDR)
				wb_seen = 1'b1;
			if (reg_write)
				check_reg({name, "_write_addr"}, t_word[idx][23:20], reg_write_addr); // rA
			if (marsel == MAR_ALU)
				mar_seen = 1'b1;
			if (a_write && b_write && !opr_seen)
			begin
				opr_seen = 1'b1; // operand latch right after decode
				rd1_got = reg_read_addr1;
				rd2_got = reg_read_addr2;
			end
			prev_dstall = datbus_stall;
			halt_got = halt;
			done = ir_write || halt; // back in fetch, or stopped
			if (done)
				check_bit({name, "_datbus_idle"}, 1'b0, datbus_cyc);
			@(posedge clk_i);
			cycles++;
		end
		datbus_stall <= 1'b1;

		if (stray != 0)
		begin
			$display("%s: instruction bus active outside its single fetch", name);
			err_count++;
		end
		dstb_exp = (kind == 4 || kind == 5) ? 1 : 0;
		if (dstb_count != dstb_exp)
		begin
			$display("[FAIL] %s_data_strobes expected %0d actual %0d", name, dstb_exp,
				dstb_count);
			err_count++;
		end
		check_bit({name, "_mar_load"}, kind == 4 || kind == 5, mar_seen);
		check_bit({name, "_halt"}, kind == 6, halt_got);
		case (kind)
			1:
			begin
				check_bit({name, "_alu_seen"}, 1'b1, alu_seen);
				check_alu({name, "_alu_func"}, alu_func_t'(exp[2:0]), alu_got);
				check_sel({name, "_alu2sel"}, t_word[idx][27] ? ALU_SVAL : ALU_B, sel_got);
				check_reg({name, "_read_addr1"}, t_word[idx][19:16], rd1_got);
				check_reg({name, "_read_addr2"}, t_word[idx][15:12], rd2_got);
			end
			2:
			begin
				check_bit({name, "_ccr_write"}, 1'b1, alu_seen);
				check_alu({name, "_alu_func"}, alu_func_t'(exp[2:0]), alu_got);
			end
			3: check_pc({name, "_pcsel"}, exp[0] ? PC_REL : PC_PC, rel_seen ? PC_REL : PC_PC);
			4, 5:
			begin
				check_be({name, "_byteenable"}, exp[BE_W-1:0], be_got);
				check_bit({name, "_write"}, kind == 5, wr_got);
				check_reg({name, "_base_addr"}, t_word[idx][19:16], rd1_got);
				if (kind == 4)
					check_bit({name, "_writeback"}, 1'b1, wb_seen);
			end
			default: ;
		endcase

		if (halt_got)
		begin
			stray = 0;
			insbus_stall <= 1'b0; // let it fetch if it would
			repeat (10)
			begin
				@(negedge clk_i);
				if (!halt || insbus_stb)
					stray++;
				@(posedge clk_i);
			end
			insbus_stall <= 1'b1;
			if (stray != 0)
			begin
				$display("%s: halt dropped or a fetch started after halt", name);
				err_count++;
			end
			apply_reset();
		end

		if (err_count != errs_before)
			test_fail++;
		$display("%-14s %s", name, (err_count == errs_before) ? "ok" : "FAILED");
	endtask

	initial
	begin
		int i;
		int max_stall;
		rst_i <= 1'b1;
		ir <= '0;
		ccr <= '0;
		insbus_ack <= 1'b0;
		insbus_stall <= 1'b1; // instruction bus idles stalled
		datbus_ack <= 1'b0;
		datbus_stall <= 1'b1;
		datbus_align <= 2'd0;
		read_tests();
		max_stall = 0;
		for (i = 0; i < t_stall.size(); i++)
			if (t_stall[i] > max_stall)
				max_stall = t_stall[i];
		wd_limit = t_kind.size() * (40 + max_stall) + 10;
		apply_reset();
		for (i = 0; i < t_kind.size(); i++)
			run_test(i);
		$display("tests: %0d run, %0d passed, %0d failed, %0d check errors", t_kind.size(),
			t_kind.size() - test_fail, test_fail, err_count);
		if (err_count == 0 && t_kind.size() > 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

/* control_input.txt */
# kind: 0 nop, 1 alu, 2 cmp, 3 branch, 4 load, 5 store, 6 halt or illegal
# kind word flags(ltu lt eq) align stall(dec) expected(alu func, taken, byteenable or halt)
0 00000000 0 0 0 0
1 73120000 0 0 0 3
1 7a450000 0 0 2 2
1 7f000000 0 0 1 7
2 31200000 0 0 0 1
3 b0000000 0 0 0 1
3 b1000000 1 0 0 1
3 b1000000 0 0 1 0
3 b3000000 0 0 0 1
3 b4000000 2 0 0 0
3 b5000000 4 0 2 1
3 b6000000 1 0 0 1
3 b9000000 4 0 0 1
3 ba000000 0 0 3 0
3 bc000000 7 0 0 0
4 90120000 0 0 0 f
4 91120000 0 2 5 3
4 92340000 0 1 4 4
4 92000000 0 0 1 8
5 a1560000 0 1 0 c
5 a2560000 0 3 6 1
5 a3000000 0 2 2 f
6 01000000 0 0 0 1
6 50000000 0 0 0 1
6 70000001 0 0 2 1

/* src.f */
ctrl_pkg.sv
decode_if.sv
insn_decode.sv
dbus_master.sv
step_sequencer.sv
control_unit.sv
tb_control_unit.sv

/* run_sim.sh */
#!/bin/sh
# build and run the control unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -f src.f --top-module tb_control_unit > build.log 2>&1
then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/Vtb_control_unit > sim.log 2>&1
status=$?
cat sim.log
if [ "$status" -ne 0 ]
then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation passed" sim.log
then
	exit 0
fi
exit 1
